// File: include/trx_defs.svh
`ifndef TRX_DEFS_SVH
`define TRX_DEFS_SVH

// Command bytes sent with data_sync
`define TRX_CMD_BUS_TEST    8'd0
`define TRX_CMD_GET_PARAMS  8'd1
`define TRX_CMD_SEND_PARAMS 8'd2
`define TRX_CMD_TX_IQ       8'd3
`define TRX_CMD_RX_IQ       8'd4
`define TRX_CMD_AUDIO_ON    8'd5
`define TRX_CMD_AUDIO_OFF   8'd6

`define TRX_ADR_CFG         3'd0 // Flags 29:24, tuning word 21:0
`define TRX_ADR_TXIQ        3'd1 // Q high, I low
`define TRX_ADR_AUDIO       3'd2
`define TRX_ADR_STATUS      3'd3 // dac_otr bit 1, adc_otr bit 0
`define TRX_ADR_PEAK        3'd4 // Min high, max low
`define TRX_ADR_SPEC        3'd5
`define TRX_ADR_VOICE       3'd6

`define TRX_FREQ_DEFAULT    22'd242347

`define TRX_PEAK_MIN_INIT   16'sd2000
`define TRX_PEAK_MAX_INIT   (-16'sd2000)

`endif

// File: project.f
+incdir+include
source/trx_pkg.sv
source/adc_peak_detector.sv
source/trx_regs.sv
source/mcu_link.sv
source/sdr_interface_top.sv
testbench/tb_clock.sv
testbench/tb_top.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
	--top-module tb_top -Mdir obj_dir -o sim -f project.f

out=$(./obj_dir/sim)
echo "$out"

if echo "$out" | grep -qx "Simulation passed"
then
	exit 0
fi
exit 1

// File: source/adc_peak_detector.sv
`include "trx_defs.svh"

module adc_peak_detector (
	input  logic               adcclk_in,
	input  logic               ADC_MINMAX_RESET,
	input  logic               clear,
	input  logic signed [15:0] adc_in,
	output logic signed [15:0] peak_min,
	output logic signed [15:0] peak_max
);

	logic               restart;
	logic signed [15:0] base_min;
	logic signed [15:0] base_max;

	assign restart = ADC_MINMAX_RESET || clear;

	// Fresh window still takes this cycle's sample
	assign base_min = restart ? `TRX_PEAK_MIN_INIT : peak_min;
	assign base_max = restart ? `TRX_PEAK_MAX_INIT : peak_max;

	always_ff @(posedge adcclk_in)
	begin
		peak_min <= (adc_in < base_min) ? adc_in : base_min;
		peak_max <= (adc_in > base_max) ? adc_in : base_max;
	end

endmodule

// File: source/mcu_link.sv
`include "trx_defs.svh"

module mcu_link (
	input  logic             adcclk_in,
	input  logic             ADC_MINMAX_RESET,
	input  logic             data_sync,
	input  logic             bus_strobe,
	input  logic [7:0]       bus_in,
	output logic [7:0]       bus_out,
	output logic             bus_oe,
	output logic             bus_ready,
	output trx_pkg::wb_req_t wb_req,
	input  trx_pkg::wb_rsp_t wb_rsp
);

	typedef enum logic [2:0] {
		ST_IDLE,
		ST_RECV, // Bytes from the MCU
		ST_SEND, // Bytes to the MCU
		ST_ECHO,
		ST_WB,
		ST_GAP   // Bus idle cycle after ack
	} state_t;

	state_t      state_q;
	logic [7:0]  cmd_q;
	logic [2:0]  cnt_q;
	logic [5:0]  flags_q;
	logic [7:0]  status_q;
	logic [23:0] rx_shift;
	logic [39:0] tx_shift;
	logic        echo_vld_q;
	logic        we_q;
	logic [2:0]  adr_q;
	logic [31:0] wdat_q;
	logic [2:0]  send_last;

	assign bus_ready = (state_q == ST_IDLE) || (state_q == ST_RECV) ||
		(state_q == ST_SEND) || (state_q == ST_ECHO);
	assign bus_oe = (state_q == ST_SEND) || ((state_q == ST_ECHO) && echo_vld_q);
	assign bus_out = tx_shift[39:32]; // Current byte, MSB first
	assign send_last = (cmd_q == `TRX_CMD_SEND_PARAMS) ? 3'd4 : 3'd3;

	assign wb_req.cyc = (state_q == ST_WB);
	assign wb_req.stb = (state_q == ST_WB);
	assign wb_req.we  = we_q;
	assign wb_req.adr = adr_q;
	assign wb_req.dat = wdat_q;

	always_ff @(posedge adcclk_in)
	begin
		if (ADC_MINMAX_RESET)
		begin
			state_q    <= ST_IDLE;
			cmd_q      <= `TRX_CMD_BUS_TEST;
			cnt_q      <= 3'd0;
			echo_vld_q <= 1'b0;
		end
		else if (data_sync && bus_ready) // New command, drops whatever was running
		begin
			cmd_q      <= bus_in;
			cnt_q      <= 3'd0;
			echo_vld_q <= 1'b0;
			we_q       <= 1'b0;
			wdat_q     <= 32'd0;
			case (bus_in)
				`TRX_CMD_BUS_TEST:   state_q <= ST_ECHO;
				`TRX_CMD_GET_PARAMS: state_q <= ST_RECV;
				`TRX_CMD_TX_IQ:      state_q <= ST_RECV;
				`TRX_CMD_SEND_PARAMS:
				begin
					adr_q   <= `TRX_ADR_STATUS;
					state_q <= ST_WB;
				end
				`TRX_CMD_RX_IQ:
				begin
					adr_q   <= `TRX_ADR_SPEC;
					state_q <= ST_WB;
				end
				`TRX_CMD_AUDIO_ON, `TRX_CMD_AUDIO_OFF:
				begin
					we_q    <= 1'b1;
					adr_q   <= `TRX_ADR_AUDIO;
					wdat_q  <= {31'd0, bus_in == `TRX_CMD_AUDIO_ON};
					state_q <= ST_WB;
				end
				default: state_q <= ST_IDLE;
			endcase
		end
		else
		begin
			case (state_q)
				ST_RECV:
				begin
					if (bus_strobe)
					begin
						rx_shift <= {rx_shift[15:0], bus_in};
						cnt_q    <= cnt_q + 3'd1;
						if ((cmd_q == `TRX_CMD_GET_PARAMS) && (cnt_q == 3'd0))
						begin
							// Flags go out at once, word field zero keeps the old tuning
							flags_q <= bus_in[5:0];
							we_q    <= 1'b1;
							adr_q   <= `TRX_ADR_CFG;
							wdat_q  <= {2'b00, bus_in[5:0], 24'd0};
							state_q <= ST_WB;
						end
						else if (cnt_q == 3'd3)
						begin
							we_q    <= 1'b1;
							state_q <= ST_WB;
							if (cmd_q == `TRX_CMD_GET_PARAMS)
							begin
								adr_q  <= `TRX_ADR_CFG;
								wdat_q <= {2'b00, flags_q, 2'b00, rx_shift[13:0], bus_in};
							end
							else
							begin
								adr_q  <= `TRX_ADR_TXIQ;
								wdat_q <= {rx_shift, bus_in}; // Q hi, Q lo, I hi, I lo
							end
						end
					end
				end
				ST_SEND:
				begin
					if (bus_strobe)
					begin
						tx_shift <= {tx_shift[31:0], 8'd0};
						cnt_q    <= cnt_q + 3'd1;
						if (cnt_q == send_last)
						begin
							if ((cmd_q == `TRX_CMD_RX_IQ) && (adr_q == `TRX_ADR_SPEC))
							begin
								adr_q   <= `TRX_ADR_VOICE; // Second half of RX IQ
								state_q <= ST_WB;
							end
							else
							begin
								state_q <= ST_IDLE;
							end
						end
					end
				end
				ST_ECHO:
				begin
					if (bus_strobe)
					begin
						tx_shift   <= {bus_in, 32'd0};
						echo_vld_q <= 1'b1;
					end
				end
				ST_WB:
				begin
					if (wb_rsp.ack)
					begin
						state_q <= ST_GAP;
						if (!we_q)
						begin
							case (adr_q)
								`TRX_ADR_STATUS: status_q <= wb_rsp.dat[7:0];
								`TRX_ADR_PEAK:   tx_shift <= {status_q, wb_rsp.dat};
								default:         tx_shift <= {wb_rsp.dat, 8'd0};
							endcase
						end
					end
				end
				ST_GAP:
				begin
					state_q <= ST_IDLE;
					case (cmd_q)
						`TRX_CMD_GET_PARAMS:
						begin
							if (cnt_q == 3'd1)
								state_q <= ST_RECV; // Tuning word still to come
						end
						`TRX_CMD_SEND_PARAMS:
						begin
							if (adr_q == `TRX_ADR_STATUS)
							begin
								adr_q   <= `TRX_ADR_PEAK;
								state_q <= ST_WB;
							end
							else
							begin
								cnt_q   <= 3'd0;
								state_q <= ST_SEND;
							end
						end
						`TRX_CMD_RX_IQ:
						begin
							cnt_q   <= 3'd0;
							state_q <= ST_SEND;
						end
						default: state_q <= ST_IDLE;
					endcase
				end
				default: state_q <= ST_IDLE;
			endcase
		end
	end

	// Master keeps the strobe up until the slave answers
	a_stb_until_ack: assert property (@(posedge adcclk_in) disable iff (ADC_MINMAX_RESET)
		wb_req.stb && !wb_rsp.ack |=> wb_req.stb);

endmodule

// File: source/sdr_interface_top.sv
module sdr_interface_top (
	input  logic               adcclk_in,
	input  logic               ADC_MINMAX_RESET,
	input  logic               data_sync,
	input  logic               bus_strobe,
	input  logic [7:0]         bus_in,
	output logic [7:0]         bus_out,
	output logic               bus_oe,
	output logic               bus_ready,
	input  logic signed [15:0] adc_in,
	input  logic               adc_otr,
	input  logic               dac_otr,
	input  logic signed [15:0] spec_i,
	input  logic signed [15:0] spec_q,
	input  logic signed [15:0] voice_i,
	input  logic signed [15:0] voice_q,
	output logic [21:0]        freq_out,
	output logic               rx,
	output logic               tx,
	output logic               preamp_enable,
	output logic               adc_pga,
	output logic               adc_rand,
	output logic               adc_shdn,
	output logic               adc_dith,
	output logic signed [15:0] tx_i,
	output logic signed [15:0] tx_q,
	output logic               audio_clk_en
);

	trx_pkg::wb_req_t    wb_req;
	trx_pkg::wb_rsp_t    wb_rsp;
	trx_pkg::radio_cfg_t radio_cfg;
	logic signed [15:0]  peak_min;
	logic signed [15:0]  peak_max;
	logic                peak_clear;

	assign freq_out      = radio_cfg.freq;
	assign tx            = radio_cfg.tx;
	assign rx            = !radio_cfg.tx;
	assign preamp_enable = radio_cfg.preamp_enable;
	assign adc_pga       = radio_cfg.adc_pga;
	assign adc_rand      = radio_cfg.adc_rand;
	assign adc_shdn      = radio_cfg.adc_shdn;
	assign adc_dith      = radio_cfg.adc_dith;

	mcu_link link_i (
		.adcclk_in        (adcclk_in),
		.ADC_MINMAX_RESET (ADC_MINMAX_RESET),
		.data_sync        (data_sync),
		.bus_strobe       (bus_strobe),
		.bus_in           (bus_in),
		.bus_out          (bus_out),
		.bus_oe           (bus_oe),
		.bus_ready        (bus_ready),
		.wb_req           (wb_req),
		.wb_rsp           (wb_rsp)
	);

	trx_regs regs_i (
		.adcclk_in        (adcclk_in),
		.ADC_MINMAX_RESET (ADC_MINMAX_RESET),
		.wb_req           (wb_req),
		.wb_rsp           (wb_rsp),
		.spec_i           (spec_i),
		.spec_q           (spec_q),
		.voice_i          (voice_i),
		.voice_q          (voice_q),
		.adc_otr          (adc_otr),
		.dac_otr          (dac_otr),
		.peak_min         (peak_min),
		.peak_max         (peak_max),
		.peak_clear       (peak_clear),
		.radio_cfg        (radio_cfg),
		.tx_i             (tx_i),
		.tx_q             (tx_q),
		.audio_clk_en     (audio_clk_en)
	);

	adc_peak_detector peak_i (
		.adcclk_in        (adcclk_in),
		.ADC_MINMAX_RESET (ADC_MINMAX_RESET),
		.clear            (peak_clear),
		.adc_in           (adc_in),
		.peak_min         (peak_min),
		.peak_max         (peak_max)
	);

endmodule

// File: source/trx_pkg.sv
package trx_pkg;

	// Wishbone classic master to slave
	typedef struct packed {
		logic        cyc;
		logic        stb;
		logic        we;
		logic [2:0]  adr;
		logic [31:0] dat;
	} wb_req_t;

	typedef struct packed {
		logic        ack;
		logic [31:0] dat; // Read data, valid with ack
	} wb_rsp_t;

	// Radio control word, flags in the same order as the CFG register bits
	typedef struct packed {
		logic        adc_pga;
		logic        adc_rand;
		logic        adc_shdn;
		logic        adc_dith;
		logic        preamp_enable;
		logic        tx;    // rx is derived as its inverse
		logic [21:0] freq;  // Tuning word
	} radio_cfg_t;

endpackage

// File: source/trx_regs.sv
`include "trx_defs.svh"

module trx_regs (
	input  logic                adcclk_in,
	input  logic                ADC_MINMAX_RESET,
	input  trx_pkg::wb_req_t    wb_req,
	output trx_pkg::wb_rsp_t    wb_rsp,
	input  logic signed [15:0]  spec_i,
	input  logic signed [15:0]  spec_q,
	input  logic signed [15:0]  voice_i,
	input  logic signed [15:0]  voice_q,
	input  logic                adc_otr,
	input  logic                dac_otr,
	input  logic signed [15:0]  peak_min,
	input  logic signed [15:0]  peak_max,
	output logic                peak_clear,
	output trx_pkg::radio_cfg_t radio_cfg,
	output logic signed [15:0]  tx_i,
	output logic signed [15:0]  tx_q,
	output logic                audio_clk_en
);

	logic        ack_q;
	logic [31:0] rdat_q;
	logic [31:0] rd_mux;
	logic        access;
	logic        wr_commit;

	assign access    = wb_req.cyc && wb_req.stb && !ack_q; // First cycle of a transfer
	assign wr_commit = wb_req.cyc && wb_req.stb && wb_req.we && ack_q;

	// Window restarts on the edge that captures the read
	assign peak_clear = access && !wb_req.we && (wb_req.adr == `TRX_ADR_PEAK);

	assign wb_rsp.ack = ack_q;
	assign wb_rsp.dat = rdat_q;

	always_comb
	begin
		case (wb_req.adr)
			`TRX_ADR_CFG:    rd_mux = {2'b00, radio_cfg[27:22], 2'b00, radio_cfg.freq};
			`TRX_ADR_TXIQ:   rd_mux = {tx_q, tx_i};
			`TRX_ADR_AUDIO:  rd_mux = {31'd0, audio_clk_en};
			`TRX_ADR_STATUS: rd_mux = {30'd0, dac_otr, adc_otr};
			`TRX_ADR_PEAK:   rd_mux = {peak_min, peak_max};
			`TRX_ADR_SPEC:   rd_mux = {spec_q, spec_i};
			`TRX_ADR_VOICE:  rd_mux = {voice_q, voice_i};
			default:         rd_mux = 32'd0;
		endcase
	end

	always_ff @(posedge adcclk_in)
	begin
		if (access)
			rdat_q <= rd_mux; // Samples SPEC/VOICE as read
	end

	always_ff @(posedge adcclk_in)
	begin
		if (ADC_MINMAX_RESET)
		begin
			ack_q        <= 1'b0;
			radio_cfg    <= {6'd0, `TRX_FREQ_DEFAULT};
			tx_i         <= 16'sd0;
			tx_q         <= 16'sd0;
			audio_clk_en <= 1'b1;
		end
		else
		begin
			ack_q <= access;
			if (wr_commit) // Outputs move the cycle after ack
			begin
				case (wb_req.adr)
					`TRX_ADR_CFG:
					begin
						radio_cfg.adc_pga       <= wb_req.dat[29];
						radio_cfg.adc_rand      <= wb_req.dat[28];
						radio_cfg.adc_shdn      <= wb_req.dat[27];
						radio_cfg.adc_dith      <= wb_req.dat[26];
						radio_cfg.preamp_enable <= wb_req.dat[25];
						radio_cfg.tx            <= wb_req.dat[24];
						if (wb_req.dat[21:0] != 22'd0) // Zero word is never a valid tuning
							radio_cfg.freq <= wb_req.dat[21:0];
					end
					`TRX_ADR_TXIQ:
					begin
						tx_q <= wb_req.dat[31:16];
						tx_i <= wb_req.dat[15:0];
					end
					`TRX_ADR_AUDIO: audio_clk_en <= wb_req.dat[0];
					default: ;
				endcase
			end
		end
	end

	// Request seen at access is still the one committed at ack
	a_req_held: assert property (@(posedge adcclk_in) disable iff (ADC_MINMAX_RESET)
		ack_q |-> wb_req.stb && $stable({wb_req.we, wb_req.adr}));

endmodule

// File: testbench/tb_clock.sv
module tb_clock (
	output logic adcclk_in,
	output logic ADC_MINMAX_RESET
);
	timeunit 1ns;
	timeprecision 1ps;

	initial
	begin
		adcclk_in = 1'b0;
		forever
			#10 adcclk_in = ~adcclk_in; // 20 ns period
	end

	initial
	begin
		ADC_MINMAX_RESET = 1'b1;
		repeat (5) @(posedge adcclk_in);
		@(negedge adcclk_in);
		ADC_MINMAX_RESET = 1'b0;
	end

endmodule

// File: testbench/tb_top.sv
`include "trx_defs.svh"

module tb_top;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int NUM_XACT = 44; // Commands plus bytes over all tests
	localparam int SEQ_LEN  = 12;

	logic               adcclk_in;
	logic               ADC_MINMAX_RESET;
	logic               data_sync;
	logic               bus_strobe;
	logic [7:0]         bus_in;
	logic [7:0]         bus_out;
	logic               bus_oe;
	logic               bus_ready;
	logic signed [15:0] adc_in;
	logic               adc_otr;
	logic               dac_otr;
	logic signed [15:0] spec_i, spec_q, voice_i, voice_q;
	logic [21:0]        freq_out;
	logic               rx, tx, preamp_enable;
	logic               adc_pga, adc_rand, adc_shdn, adc_dith;
	logic signed [15:0] tx_i, tx_q;
	logic               audio_clk_en;
	int                 errors;

	tb_clock clock_i (
		.adcclk_in        (adcclk_in),
		.ADC_MINMAX_RESET (ADC_MINMAX_RESET)
	);

	sdr_interface_top dut_i (.*);

	task automatic check_equal(input logic [31:0] got, input logic [31:0] exp, input string what);
		assert (got === exp)
		else
		begin
			$display("ERROR %0d ns: %s is %0h, expected %0h", $time, what, got, exp);
			errors++;
		end
	endtask

	task automatic wait_ready();
		while (!bus_ready)
			@(negedge adcclk_in);
	endtask

	task automatic send_command(input logic [7:0] cmd);
		wait_ready();
		bus_in    = cmd;
		data_sync = 1'b1;
		@(negedge adcclk_in);
		data_sync = 1'b0;
	endtask

	task automatic write_byte(input logic [7:0] b);
		wait_ready();
		bus_in     = b;
		bus_strobe = 1'b1;
		@(negedge adcclk_in);
		bus_strobe = 1'b0;
	endtask

	task automatic read_byte(output logic [7:0] b);
		wait_ready();
		check_equal(32'(bus_oe), 32'd1, "bus_oe during read");
		b          = bus_out; // Strobe consumes the shown byte
		bus_strobe = 1'b1;
		@(negedge adcclk_in);
		bus_strobe = 1'b0;
	endtask

	task automatic widen_window(inout logic signed [15:0] lo, inout logic signed [15:0] hi,
		input logic signed [15:0] v);
		if (v < lo)
			lo = v;
		if (v > hi)
			hi = v;
	endtask

	task automatic expect_params(input logic [7:0] status, input logic [15:0] lo,
		input logic [15:0] hi);
		logic [7:0]  b;
		logic [39:0] exp;
		exp = {status, lo, hi};
		send_command(`TRX_CMD_SEND_PARAMS);
		for (int k = 4; k >= 0; k--)
		begin
			read_byte(b);
			check_equal(32'(b), 32'(exp[k*8 +: 8]), "send params byte");
		end
	endtask

	task automatic reset_values();
		check_equal(32'(bus_ready), 32'd1, "bus_ready after reset");
		check_equal(32'(bus_oe), 32'd0, "bus_oe after reset");
		check_equal(32'({adc_pga, adc_rand, adc_shdn, adc_dith, preamp_enable, tx}), 32'd0,
			"control bits after reset");
		check_equal(32'(rx), 32'd1, "rx after reset");
		check_equal(32'(audio_clk_en), 32'd1, "audio_clk_en after reset");
		check_equal({tx_q, tx_i}, 32'd0, "tx_q/tx_i after reset");
		check_equal(32'(freq_out), 32'(`TRX_FREQ_DEFAULT), "freq_out after reset");
	endtask

	task automatic get_params_flow();
		logic [5:0]  flags;
		logic [21:0] word;
		flags = 6'($urandom());
		word  = 22'($urandom_range(32'h003f_ffff, 1));
		send_command(`TRX_CMD_GET_PARAMS);
		write_byte({2'b00, flags}); // pga, rand, shdn, dith, preamp, tx
		write_byte({2'b00, word[21:16]});
		write_byte(word[15:8]);
		write_byte(word[7:0]);
		wait_ready();
		check_equal(32'({adc_pga, adc_rand, adc_shdn, adc_dith, preamp_enable, tx}),
			32'(flags), "flag outputs");
		check_equal(32'(rx), 32'(!flags[0]), "rx");
		check_equal(32'(freq_out), 32'(word), "freq_out");
	endtask

	task automatic tx_iq_load();
		logic [15:0] i_val;
		logic [15:0] q_val;
		i_val = 16'($urandom());
		q_val = 16'($urandom());
		send_command(`TRX_CMD_TX_IQ);
		write_byte(q_val[15:8]);
		write_byte(q_val[7:0]);
		write_byte(i_val[15:8]);
		write_byte(i_val[7:0]);
		wait_ready();
		check_equal({tx_q, tx_i}, {q_val, i_val}, "tx_q/tx_i");
	endtask

	task automatic peak_readback();
		logic signed [15:0] seq [SEQ_LEN];
		logic signed [15:0] lo;
		logic signed [15:0] hi;
		logic signed [15:0] fresh;
		logic [7:0]         junk;
		lo = `TRX_PEAK_MIN_INIT;
		hi = `TRX_PEAK_MAX_INIT;
		for (int k = 0; k < SEQ_LEN; k++)
		begin
			seq[k] = 16'($urandom());
			widen_window(lo, hi, seq[k]);
		end
		adc_otr = 1'b1;
		dac_otr = 1'b1;
		adc_in  = seq[0];
		send_command(`TRX_CMD_SEND_PARAMS); // Window restarts on seq[0]
		for (int k = 0; k < 5; k++)
			read_byte(junk);
		for (int k = 1; k < SEQ_LEN; k++)
		begin
			adc_in = seq[k];
			@(negedge adcclk_in);
		end
		expect_params(8'b0000_0011, lo, hi);

		// Window reopens on the sample held at the clear
		fresh   = 16'($urandom());
		lo      = `TRX_PEAK_MIN_INIT;
		hi      = `TRX_PEAK_MAX_INIT;
		widen_window(lo, hi, seq[SEQ_LEN-1]);
		widen_window(lo, hi, fresh);
		adc_otr = 1'b0;
		adc_in  = fresh;
		@(negedge adcclk_in);
		expect_params(8'b0000_0010, lo, hi);
	endtask

	task automatic rx_iq_readout();
		logic [63:0] pairs;
		logic [7:0]  b;
		pairs = {$urandom(), $urandom()};
		{spec_q, spec_i, voice_q, voice_i} = pairs;
		send_command(`TRX_CMD_RX_IQ);
		for (int k = 7; k >= 0; k--)
		begin
			read_byte(b);
			check_equal(32'(b), 32'(pairs[k*8 +: 8]), "rx iq byte");
		end
	endtask

	task automatic echo_and_audio();
		logic [7:0] b;
		send_command(`TRX_CMD_BUS_TEST);
		check_equal(32'(bus_oe), 32'd0, "bus_oe before first echo");
		for (int k = 0; k < 4; k++)
		begin
			b = 8'($urandom());
			write_byte(b);
			check_equal(32'(bus_oe), 32'd1, "bus_oe during echo");
			check_equal(32'(bus_out), 32'(b), "echoed byte");
		end
		send_command(`TRX_CMD_AUDIO_OFF);
		wait_ready();
		check_equal(32'(audio_clk_en), 32'd0, "audio_clk_en after off");
		send_command(`TRX_CMD_AUDIO_ON);
		wait_ready();
		check_equal(32'(audio_clk_en), 32'd1, "audio_clk_en after on");
	endtask

	initial
	begin
		errors     = 0;
		data_sync  = 1'b0;
		bus_strobe = 1'b0;
		bus_in     = 8'd0;
		adc_in     = 16'sd0;
		adc_otr    = 1'b0;
		dac_otr    = 1'b0;
		{spec_q, spec_i, voice_q, voice_i} = 64'd0;
		void'($urandom(32'heb98_f69c));
		@(negedge ADC_MINMAX_RESET);
		@(negedge adcclk_in);
		reset_values();
		get_params_flow();
		tx_iq_load();
		peak_readback();
		rx_iq_readout();
		echo_and_audio();
		$display("Checks done with %0d errors", errors);
		if (errors == 0)
			$display("Simulation passed");
		else
			$display("Simulation failed");
		$finish;
	end

	// Watchdog
	initial
	begin
		repeat (200 * NUM_XACT) @(posedge adcclk_in);
		$display("Timeout: the bus model waited too long for bus_ready");
		$display("Simulation failed");
		$finish;
	end

endmodule
